// File: Bender.yml
package:
  name: cache_subsys

sources:
  - cache_pkg.sv
  - cache_way_hit.sv
  - cache_ctrl.sv
  - mem_arbiter.sv
  - cache_subsys.sv
  - target: test
    files:
      - tb_axil_mem.sv
      - tb_cache_subsys.sv

// File: cache_ctrl.sv
// Read-only 4-way cache with its tag, valid and data arrays and the line refill FSM
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	input  logic                         client_req,
	input  logic [cache_pkg::addr_w-1:0] client_addr,
	output logic                         client_ready,
	output logic                         client_rvalid,
	output logic [cache_pkg::data_w-1:0] client_rdata,
	output logic                         refill_req,
	output logic [cache_pkg::addr_w-1:0] refill_addr,
	input  logic                         refill_gnt,
	input  logic                         refill_valid,
	input  logic [cache_pkg::data_w-1:0] refill_data,
	input  logic                         refill_last
);

	import cache_pkg::*;

	// ========================================================================
	// Storage
	// ========================================================================

	// Tags of all ways of a set are read together for the compare
	logic [ways-1:0][tag_w-1:0] tag_mem [sets];
	logic [ways-1:0]            valid_mem [sets];
	logic [data_w-1:0]          data_mem [sets][ways][words_per_line];

	// ========================================================================
	// Control and lookup signals
	// ========================================================================

	logic [st_w-1:0]   state;
	logic              accept;

	// Incoming request, the latched miss and the line base sent for refill
	cache_addr_u       req_a;
	cache_addr_u       miss_a;
	cache_addr_u       line_a;
	logic [word_w-1:0] req_word;
	logic [word_w-1:0] miss_word;

	// Way-hit results for the set addressed by the request
	logic              lookup_hit;
	logic [way_w-1:0]  hit_way;
	logic              has_free;
	logic [way_w-1:0]  free_way;

	// Way being refilled, and whether that refill throws out a valid line
	logic [way_w-1:0]  victim;
	logic              evict;

	// Round-robin replacement pointer shared by all sets of this cache
	logic [way_w-1:0]  victim_ptr;

	// Beat number within the line being filled
	logic [word_w-1:0] fill_cnt;

	assign req_a     = client_addr;
	assign req_word  = req_a.f.off[off_w-1 -: word_w];
	assign miss_word = miss_a.f.off[off_w-1 -: word_w];

	// The line base is the missed address with its offset cleared
	always_comb
	begin
		line_a       = miss_a;
		line_a.f.off = '0;
	end

	assign refill_addr = line_a.raw;
	assign refill_req  = (state == cc_req);

	// Requests are taken while idle and also in the response cycle of a miss;
	// a flush holds the port off for the one cycle it takes
	assign client_ready = (state == cc_resp) || ((state == cc_idle) && !flush);
	assign accept       = client_req && client_ready;

	cache_way_hit i_way_hit (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_tag  (req_a.f.tag),
		.set_tags (tag_mem[req_a.f.idx]),
		.set_valid(valid_mem[req_a.f.idx]),
		.hit      (lookup_hit),
		.hit_way  (hit_way),
		.has_free (has_free),
		.free_way (free_way)
	);

	// ========================================================================
	// Control FSM
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state         <= cc_idle;
			client_rvalid <= 1'b0;
			victim_ptr    <= '0;
			fill_cnt      <= '0;
			for (int s = 0; s < sets; s++)
			begin
				valid_mem[s] <= '0;
			end
		end
		else
		begin
			// The response strobe is a single-cycle pulse
			client_rvalid <= 1'b0;

			case (state)
			cc_idle, cc_resp:
			begin
				if ((state == cc_idle) && flush)
				begin
					// Forget every line and restart replacement at way 0
					for (int s = 0; s < sets; s++)
					begin
						valid_mem[s] <= '0;
					end
					victim_ptr <= '0;
				end
				else if (accept && lookup_hit)
				begin
					client_rvalid <= 1'b1;
					state         <= cc_idle;
				end
				else if (accept)
				begin
					state <= cc_req;
				end
				else
				begin
					state <= cc_idle;
				end
			end

			cc_req:
			begin
				// Hold the request until the arbiter grants the memory
				if (refill_gnt)
				begin
					fill_cnt <= '0;
					state    <= cc_fill;
				end
			end

			cc_fill:
			begin
				if (refill_valid)
				begin
					fill_cnt <= fill_cnt + 1'b1;
					if (refill_last)
					begin
						// Line complete, so it becomes visible and the client is answered
						valid_mem[miss_a.f.idx][victim] <= 1'b1;
						if (evict)
							victim_ptr <= victim_ptr + 1'b1;
						client_rvalid <= 1'b1;
						state         <= cc_resp;
					end
				end
			end

			default:
			begin
				state <= cc_idle;
			end
			endcase
		end
	end

	// ========================================================================
	// Data path and arrays
	// ========================================================================

	always_ff @(posedge clk)
	begin
		// Hit data is registered for a response one cycle after acceptance
		if (accept && lookup_hit)
			client_rdata <= data_mem[req_a.f.idx][hit_way][req_word];

		// On a miss take a free way if the set has one, else the pointer way
		if (accept && !lookup_hit)
		begin
			miss_a <= req_a;
			victim <= has_free ? free_way : victim_ptr;
			evict  <= !has_free;
		end

		// Refill beats arrive in word order; the requested word is kept aside
		// for the response and the tag lands with the last beat
		if ((state == cc_fill) && refill_valid)
		begin
			data_mem[miss_a.f.idx][victim][fill_cnt] <= refill_data;
			if (fill_cnt == miss_word)
				client_rdata <= refill_data;
			if (refill_last)
				tag_mem[miss_a.f.idx][victim] <= miss_a.f.tag;
		end
	end

endmodule

// File: cache_pkg.sv
// Cache subsystem package with geometry constants, FSM encodings and the address layout
package cache_pkg;

	// ========================================================================
	// Geometry
	// ========================================================================

	// Byte address and data word widths seen by the clients and the memory
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// Four ways of sixteen sets, each line holding four words
	localparam int ways           = 4;
	localparam int sets           = 16;
	localparam int words_per_line = 4;

	// Address field widths; tag, index and offset together cover addr_w
	localparam int off_w = 4;
	localparam int idx_w = 4;
	localparam int tag_w = addr_w - idx_w - off_w;

	// Width of a way number and of a word number within a line
	localparam int way_w  = 2;
	localparam int word_w = 2;

	// ========================================================================
	// FSM encodings
	// ========================================================================

	localparam int st_w = 2;

	// Cache controller states
	localparam logic [st_w-1:0] cc_idle = 2'd0;
	localparam logic [st_w-1:0] cc_req  = 2'd1;
	localparam logic [st_w-1:0] cc_fill = 2'd2;
	localparam logic [st_w-1:0] cc_resp = 2'd3;

	// Refill arbiter states
	localparam logic [st_w-1:0] arb_idle = 2'd0;
	localparam logic [st_w-1:0] arb_ar   = 2'd1;
	localparam logic [st_w-1:0] arb_r    = 2'd2;

	// ========================================================================
	// Request address
	// ========================================================================

	// The same 32-bit word is either handled whole, as it travels on the
	// client and refill ports, or split into the fields that address the
	// tag, valid and data arrays
	typedef union packed {
		logic [addr_w-1:0] raw;
		struct packed {
			logic [tag_w-1:0] tag;
			logic [idx_w-1:0] idx;
			logic [off_w-1:0] off;
		} f;
	} cache_addr_u;

endpackage

// File: cache_subsys.f
cache_pkg.sv
cache_way_hit.sv
cache_ctrl.sv
mem_arbiter.sv
cache_subsys.sv
tb_axil_mem.sv
tb_cache_subsys.sv

// File: cache_subsys.sv
// Cache subsystem top joining the instruction and data caches to the refill arbiter
`timescale 1ns/1ps

module cache_subsys (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	input  logic                         i_client_req,
	input  logic [cache_pkg::addr_w-1:0] i_client_addr,
	output logic                         i_client_ready,
	output logic                         i_client_rvalid,
	output logic [cache_pkg::data_w-1:0] i_client_rdata,
	input  logic                         d_client_req,
	input  logic [cache_pkg::addr_w-1:0] d_client_addr,
	output logic                         d_client_ready,
	output logic                         d_client_rvalid,
	output logic [cache_pkg::data_w-1:0] d_client_rdata,
	output logic                         arvalid,
	input  logic                         arready,
	output logic [cache_pkg::addr_w-1:0] araddr,
	output logic [2:0]                   arprot,
	input  logic                         rvalid,
	output logic                         rready,
	input  logic [cache_pkg::data_w-1:0] rdata,
	input  logic [1:0]                   rresp
);

	import cache_pkg::*;

	// Refill port of the instruction cache
	logic              i_refill_req;
	logic [addr_w-1:0] i_refill_addr;
	logic              i_refill_gnt;
	logic              i_refill_valid;
	logic [data_w-1:0] i_refill_data;
	logic              i_refill_last;

	// Refill port of the data cache
	logic              d_refill_req;
	logic [addr_w-1:0] d_refill_addr;
	logic              d_refill_gnt;
	logic              d_refill_valid;
	logic [data_w-1:0] d_refill_data;
	logic              d_refill_last;

	// ========================================================================
	// Caches
	// ========================================================================

	// Both caches see the same flush
	cache_ctrl i_icache (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.client_req   (i_client_req),
		.client_addr  (i_client_addr),
		.client_ready (i_client_ready),
		.client_rvalid(i_client_rvalid),
		.client_rdata (i_client_rdata),
		.refill_req   (i_refill_req),
		.refill_addr  (i_refill_addr),
		.refill_gnt   (i_refill_gnt),
		.refill_valid (i_refill_valid),
		.refill_data  (i_refill_data),
		.refill_last  (i_refill_last)
	);

	cache_ctrl i_dcache (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.client_req   (d_client_req),
		.client_addr  (d_client_addr),
		.client_ready (d_client_ready),
		.client_rvalid(d_client_rvalid),
		.client_rdata (d_client_rdata),
		.refill_req   (d_refill_req),
		.refill_addr  (d_refill_addr),
		.refill_gnt   (d_refill_gnt),
		.refill_valid (d_refill_valid),
		.refill_data  (d_refill_data),
		.refill_last  (d_refill_last)
	);

	// ========================================================================
	// Shared memory port
	// ========================================================================

	mem_arbiter i_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_refill_req  (i_refill_req),
		.i_refill_addr (i_refill_addr),
		.i_refill_gnt  (i_refill_gnt),
		.i_refill_valid(i_refill_valid),
		.i_refill_data (i_refill_data),
		.i_refill_last (i_refill_last),
		.d_refill_req  (d_refill_req),
		.d_refill_addr (d_refill_addr),
		.d_refill_gnt  (d_refill_gnt),
		.d_refill_valid(d_refill_valid),
		.d_refill_data (d_refill_data),
		.d_refill_last (d_refill_last),
		.arvalid       (arvalid),
		.arready       (arready),
		.araddr        (araddr),
		.arprot        (arprot),
		.rvalid        (rvalid),
		.rready        (rready),
		.rdata         (rdata),
		.rresp         (rresp)
	);

endmodule

// File: cache_way_hit.sv
// Way-hit block doing the tag compare, hit-way choice and free-way search for one set
`timescale 1ns/1ps

module cache_way_hit (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic [cache_pkg::tag_w-1:0]                     req_tag,
	input  logic [cache_pkg::ways-1:0][cache_pkg::tag_w-1:0] set_tags,
	input  logic [cache_pkg::ways-1:0]                      set_valid,
	output logic                                            hit,
	output logic [cache_pkg::way_w-1:0]                     hit_way,
	output logic                                            has_free,
	output logic [cache_pkg::way_w-1:0]                     free_way
);

	import cache_pkg::*;

	// One match bit per way, already qualified by that way's valid bit
	logic [ways-1:0]  match;

	// Way reported on the previous cycle, held while nothing hits
	logic [way_w-1:0] prev_way;

	// ========================================================================
	// Tag compare
	// ========================================================================

	always_comb
	begin
		for (int w = 0; w < ways; w++)
		begin
			match[w] = set_valid[w] && (set_tags[w] == req_tag);
		end
	end

	assign hit = |match;

	// Walk upward so that the highest matching way is the one left standing;
	// with no match the previous choice is kept
	always_comb
	begin
		hit_way = prev_way;
		for (int w = 0; w < ways; w++)
		begin
			if (match[w])
				hit_way = way_w'(w);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			prev_way <= '0;
		else
			prev_way <= hit_way;
	end

	// ========================================================================
	// Free-way search
	// ========================================================================

	// A set has room whenever at least one valid bit is clear
	assign has_free = ~&set_valid;

	// Walk downward so that the lowest invalid way wins
	always_comb
	begin
		free_way = '0;
		for (int w = ways - 1; w >= 0; w--)
		begin
			if (!set_valid[w])
				free_way = way_w'(w);
		end
	end

endmodule

// File: mem_arbiter.sv
// Round-robin line refill arbiter with an AXI4-Lite read master toward memory
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_refill_req,
	input  logic [cache_pkg::addr_w-1:0] i_refill_addr,
	output logic                         i_refill_gnt,
	output logic                         i_refill_valid,
	output logic [cache_pkg::data_w-1:0] i_refill_data,
	output logic                         i_refill_last,
	input  logic                         d_refill_req,
	input  logic [cache_pkg::addr_w-1:0] d_refill_addr,
	output logic                         d_refill_gnt,
	output logic                         d_refill_valid,
	output logic [cache_pkg::data_w-1:0] d_refill_data,
	output logic                         d_refill_last,
	output logic                         arvalid,
	input  logic                         arready,
	output logic [cache_pkg::addr_w-1:0] araddr,
	output logic [2:0]                   arprot,
	input  logic                         rvalid,
	output logic                         rready,
	input  logic [cache_pkg::data_w-1:0] rdata,
	input  logic [1:0]                   rresp
);

	import cache_pkg::*;

	logic [st_w-1:0]   state;

	// Port owning the current line, and the port that won the last line
	logic              sel_d;
	logic              last_d;

	// Port picked when a new line starts
	logic              pick_d;

	// Word number of the outstanding read and the base of the line
	logic [word_w-1:0] beat;
	logic [addr_w-1:0] line_base;

	// Read data beat accepted from memory
	logic              beat_fire;
	logic              beat_last;

	// ========================================================================
	// Arbitration
	// ========================================================================

	// A lone requester wins outright; with both asking, the port that did not
	// win last time goes first
	assign pick_d = d_refill_req && (!i_refill_req || !last_d);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state        <= arb_idle;
			sel_d        <= 1'b0;
			// Pretend the data port won last so the instruction port leads
			last_d       <= 1'b1;
			beat         <= '0;
			i_refill_gnt <= 1'b0;
			d_refill_gnt <= 1'b0;
		end
		else
		begin
			// Grants are one-cycle pulses
			i_refill_gnt <= 1'b0;
			d_refill_gnt <= 1'b0;

			case (state)
			arb_idle:
			begin
				if (i_refill_req || d_refill_req)
				begin
					sel_d        <= pick_d;
					i_refill_gnt <= !pick_d;
					d_refill_gnt <= pick_d;
					beat         <= '0;
					state        <= arb_ar;
				end
			end

			arb_ar:
			begin
				if (arready)
					state <= arb_r;
			end

			arb_r:
			begin
				if (rvalid)
				begin
					if (beat_last)
					begin
						last_d <= sel_d;
						state  <= arb_idle;
					end
					else
					begin
						beat  <= beat + 1'b1;
						state <= arb_ar;
					end
				end
			end

			default:
			begin
				state <= arb_idle;
			end
			endcase
		end
	end

	// The line base is taken with the grant and held for all four reads
	always_ff @(posedge clk)
	begin
		if ((state == arb_idle) && (i_refill_req || d_refill_req))
			line_base <= pick_d ? d_refill_addr : i_refill_addr;
	end

	// ========================================================================
	// AXI4-Lite read channels
	// ========================================================================

	// One read outstanding at a time; the address stays put until arready
	assign arvalid = (state == arb_ar);
	assign araddr  = {line_base[addr_w-1:off_w], beat, {(off_w - word_w){1'b0}}};
	assign arprot  = '0;
	assign rready  = (state == arb_r);

	// Read responses carry no error handling here, so rresp is not examined
	assign beat_fire = (state == arb_r) && rvalid;
	assign beat_last = (beat == word_w'(words_per_line - 1));

	// Each beat goes only to the port that owns the line
	assign i_refill_valid = beat_fire && !sel_d;
	assign d_refill_valid = beat_fire && sel_d;
	assign i_refill_last  = i_refill_valid && beat_last;
	assign d_refill_last  = d_refill_valid && beat_last;
	assign i_refill_data  = rdata;
	assign d_refill_data  = rdata;

endmodule

// File: tb_axil_mem.sv
// AXI4-Lite read-only memory model with rule-based content, fixed latency and an AR log
`timescale 1ns/1ps

module tb_axil_mem (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        arvalid,
	output logic        arready,
	input  logic [31:0] araddr,
	input  logic [2:0]  arprot,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp
);

	// Cycles from the AR handshake to the first cycle with rvalid high
	localparam int latency   = 3;
	localparam int log_depth = 512;

	// One read in flight at a time
	logic        busy;
	logic [31:0] addr_q;
	int          wait_cnt;

	// Handshake count and the address of every accepted read, in order
	int          ar_count;
	logic [31:0] ar_log [log_depth];

	// Handshakes that arrived with a nonzero protection type
	int          prot_count;

	// Every word holds its own address scrambled with a fixed key
	function automatic logic [31:0] word_at(input logic [31:0] a);
		return a ^ 32'hC0DE_0000;
	endfunction

	assign arready = !busy;
	assign rresp   = 2'b00;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy       <= 1'b0;
			rvalid     <= 1'b0;
			rdata      <= '0;
			addr_q     <= '0;
			wait_cnt   <= 0;
			ar_count   <= 0;
			prot_count <= 0;
		end
		else if (!busy)
		begin
			if (arvalid)
			begin
				busy     <= 1'b1;
				addr_q   <= araddr;
				wait_cnt <= latency - 1;
				ar_count <= ar_count + 1;
				if (ar_count < log_depth)
					ar_log[ar_count] <= araddr;
				if (arprot != 3'b000)
					prot_count <= prot_count + 1;
			end
		end
		else if (!rvalid)
		begin
			// Count down the latency, then present the data
			if (wait_cnt == 0)
			begin
				rvalid <= 1'b1;
				rdata  <= word_at(addr_q);
			end
			else
				wait_cnt <= wait_cnt - 1;
		end
		else if (rready)
		begin
			rvalid <= 1'b0;
			busy   <= 1'b0;
		end
	end

endmodule

// File: tb_cache_subsys.sv
// Directed testbench for the two-port read-only cache subsystem
`timescale 1ns/1ps

module tb_cache_subsys;

	localparam int ready_timeout  = 100;
	localparam int rvalid_timeout = 200;

	logic        clk;
	logic        rst_n;
	logic        flush;
	logic        i_client_req;
	logic [31:0] i_client_addr;
	logic        i_client_ready;
	logic        i_client_rvalid;
	logic [31:0] i_client_rdata;
	logic        d_client_req;
	logic [31:0] d_client_addr;
	logic        d_client_ready;
	logic        d_client_rvalid;
	logic [31:0] d_client_rdata;
	logic        arvalid;
	logic        arready;
	logic [31:0] araddr;
	logic [2:0]  arprot;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;

	// Bookkeeping for the per-test lines and the closing summary
	string test_name;
	int    test_errors;
	int    total_errors;
	int    tests_run;

	cache_subsys i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.i_client_req   (i_client_req),
		.i_client_addr  (i_client_addr),
		.i_client_ready (i_client_ready),
		.i_client_rvalid(i_client_rvalid),
		.i_client_rdata (i_client_rdata),
		.d_client_req   (d_client_req),
		.d_client_addr  (d_client_addr),
		.d_client_ready (d_client_ready),
		.d_client_rvalid(d_client_rvalid),
		.d_client_rdata (d_client_rdata),
		.arvalid        (arvalid),
		.arready        (arready),
		.araddr         (araddr),
		.arprot         (arprot),
		.rvalid         (rvalid),
		.rready         (rready),
		.rdata          (rdata),
		.rresp          (rresp)
	);

	tb_axil_mem i_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.arvalid(arvalid),
		.arready(arready),
		.araddr (araddr),
		.arprot (arprot),
		.rvalid (rvalid),
		.rready (rready),
		.rdata  (rdata),
		.rresp  (rresp)
	);

	always #5 clk = ~clk;

	// ========================================================================
	// Helpers
	// ========================================================================

	// Each word of memory holds its byte address XOR a fixed key
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return addr ^ 32'hC0DE_0000;
	endfunction

	// Same set (index 5) for every t, with tag 0x100 + t
	function automatic logic [31:0] set5_addr(input int t);
		return 32'h0001_0050 + (32'(t) << 8);
	endfunction

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		// The read channel never carries a protection type other than zero
		check_value("AR handshakes with nonzero arprot", 0, i_mem.prot_count);
		$display("[%s] %s, %0d failed checks", test_name, (test_errors == 0) ? "pass" : "fail",
			test_errors);
		total_errors += test_errors;
		tests_run++;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("** Error [%s] %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	// One read on either port; lat counts cycles from acceptance to rvalid.
	// Called and returning 1 ns after a rising edge; ready is sampled mid-cycle
	task automatic read_word(input bit port_d, input logic [31:0] addr,
		output logic [31:0] data, output int lat);
		int    cycles;
		bit    ready_seen;
		bit    got;
		string port;

		port       = port_d ? "data" : "instruction";
		data       = '0;
		lat        = 0;
		cycles     = 0;
		ready_seen = 1'b0;
		got        = 1'b0;
		if (port_d)
		begin
			d_client_req  = 1'b1;
			d_client_addr = addr;
		end
		else
		begin
			i_client_req  = 1'b1;
			i_client_addr = addr;
		end

		while (!ready_seen && (cycles < ready_timeout))
		begin
			#4;
			ready_seen = port_d ? d_client_ready : i_client_ready;
			@(posedge clk);
			#1;
			cycles++;
		end
		if (port_d)
			d_client_req = 1'b0;
		else
			i_client_req = 1'b0;
		assert (ready_seen)
		else
		begin
			$display("[%s] Timeout: the %s port was never ready for 0x%08h", test_name, port, addr);
			test_errors++;
		end

		// The response arrives no earlier than the cycle after acceptance
		if (ready_seen)
		begin
			lat = 1;
			got = port_d ? d_client_rvalid : i_client_rvalid;
			while (!got && (lat < rvalid_timeout))
			begin
				@(posedge clk);
				#1;
				lat++;
				got = port_d ? d_client_rvalid : i_client_rvalid;
			end
			data = port_d ? d_client_rdata : i_client_rdata;
			assert (got)
			else
			begin
				$display("[%s] Timeout: no response on the %s port for 0x%08h", test_name, port, addr);
				test_errors++;
			end
		end
	endtask

	// Read and check data, the number of new AR handshakes and, for hits, the latency
	task automatic read_expect(input bit port_d, input logic [31:0] addr, input int ar_delta,
		input bit is_hit);
		int          ar_before;
		logic [31:0] data;
		int          lat;

		ar_before = i_mem.ar_count;
		read_word(port_d, addr, data, lat);
		check_value($sformatf("data at 0x%08h", addr), expected_word(addr), data);
		check_value($sformatf("AR handshakes for 0x%08h", addr), ar_delta,
			i_mem.ar_count - ar_before);
		if (is_hit)
			check_value($sformatf("hit latency for 0x%08h", addr), 1, lat);
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic cold_miss_then_hit();
		start_test("cold_miss_then_hit");
		read_expect(1'b0, 32'h0000_1000, 4, 1'b0);
		read_expect(1'b0, 32'h0000_1000, 0, 1'b1);
		read_expect(1'b1, 32'h0000_2040, 4, 1'b0);
		read_expect(1'b1, 32'h0000_2040, 0, 1'b1);
		end_test();
	endtask

	task automatic line_fill();
		int first;

		start_test("line_fill");
		first = i_mem.ar_count;
		read_expect(1'b0, 32'h0000_3008, 4, 1'b0);
		read_expect(1'b0, 32'h0000_3000, 0, 1'b1);
		read_expect(1'b0, 32'h0000_3004, 0, 1'b1);
		read_expect(1'b0, 32'h0000_300C, 0, 1'b1);
		// The refill reads the whole line from its base, in word order
		for (int k = 0; k < 4; k++)
		begin
			check_value($sformatf("AR log entry %0d", k), 32'h0000_3000 + 32'(4 * k),
				i_mem.ar_log[first + k]);
		end
		end_test();
	endtask

	task automatic replacement();
		start_test("replacement");
		for (int t = 0; t < 5; t++)
		begin
			read_expect(1'b1, set5_addr(t), 4, 1'b0);
		end
		// Only tag 0 in way 0 was thrown out by the fifth fill
		for (int t = 1; t < 5; t++)
		begin
			read_expect(1'b1, set5_addr(t), 0, 1'b1);
		end
		read_expect(1'b1, set5_addr(0), 4, 1'b0);
		end_test();
	endtask

	task automatic concurrent_misses();
		logic [31:0] i_data;
		logic [31:0] d_data;
		int          i_lat;
		int          d_lat;
		int          first;

		start_test("concurrent_misses");
		// Fresh reset so the instruction port holds arbitration priority
		apply_reset();
		first = i_mem.ar_count;
		fork
			read_word(1'b0, 32'h0000_4004, i_data, i_lat);
			read_word(1'b1, 32'h0000_5008, d_data, d_lat);
		join
		check_value("instruction data", expected_word(32'h0000_4004), i_data);
		check_value("data-port data", expected_word(32'h0000_5008), d_data);
		check_value("AR handshakes", 8, i_mem.ar_count - first);
		for (int k = 0; k < 4; k++)
		begin
			check_value($sformatf("AR log entry %0d", k), 32'h0000_4000 + 32'(4 * k),
				i_mem.ar_log[first + k]);
			check_value($sformatf("AR log entry %0d", k + 4), 32'h0000_5000 + 32'(4 * k),
				i_mem.ar_log[first + 4 + k]);
		end
		end_test();
	endtask

	task automatic flush_invalidates();
		start_test("flush_invalidates");
		read_expect(1'b0, 32'h0000_6010, 4, 1'b0);
		read_expect(1'b0, 32'h0000_6010, 0, 1'b1);
		read_expect(1'b1, 32'h0000_7020, 4, 1'b0);
		read_expect(1'b1, 32'h0000_7020, 0, 1'b1);
		// One idle cycle first, since flush is only taken while idle
		@(posedge clk);
		#1;
		flush = 1'b1;
		#4;
		check_value("ready during flush", 2'b00, {i_client_ready, d_client_ready});
		@(posedge clk);
		#1;
		flush = 1'b0;
		read_expect(1'b0, 32'h0000_6010, 4, 1'b0);
		read_expect(1'b1, 32'h0000_7020, 4, 1'b0);
		end_test();
	endtask

	task automatic random_reads();
		logic [31:0] addr;
		logic [31:0] data;
		int          lat;

		start_test("random_reads");
		// A 4 KiB window keeps some lines reused so hits and misses mix
		for (int n = 0; n < 30; n++)
		begin
			addr = $urandom & 32'h0000_0FFC;
			read_word(n[0], addr, data, lat);
			check_value($sformatf("data at 0x%08h", addr), expected_word(addr), data);
		end
		end_test();
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial
	begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		flush         = 1'b0;
		i_client_req  = 1'b0;
		i_client_addr = '0;
		d_client_req  = 1'b0;
		d_client_addr = '0;
		test_name     = "";
		test_errors   = 0;
		total_errors  = 0;
		tests_run     = 0;
		void'($urandom(32'h9234));

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		cold_miss_then_hit();
		line_fill();
		replacement();
		concurrent_misses();
		flush_invalidates();
		random_reads();

		$display("Tests run: %0d, failed checks: %0d", tests_run, total_errors);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
